/* imul_pkg.sv */
// ------------------------------
// imul shared types
// FSM state and datapath selects
// ------------------------------

package imul_pkg;

  // ------------------------------
  // control FSM
  // ------------------------------

  typedef enum logic [1:0] {
    state_idle,
    state_calc,
    state_done
  } imul_state_e;

  // ------------------------------
  // datapath mux selects
  // ------------------------------

  // a register input
  typedef enum logic {
    a_load,
    a_shift
  } a_sel_e;

  // b register input
  typedef enum logic {
    b_load,
    b_shift
  } b_sel_e;

  // result register input, zero or running sum
  typedef enum logic {
    result_clear,
    result_add
  } result_sel_e;

endpackage

/* imul_zero_skip_shifter.sv */
// ------------------------------
// zero-skipping right shifter for b
// drops a run of trailing zeros
// ------------------------------

module imul_zero_skip_shifter #(
  parameter int p_nbits    = 32,
  parameter int p_max_skip = 8
) (
  input  logic [p_nbits-1:0]           b,
  input  logic [$clog2(p_nbits+1)-1:0] remaining,
  output logic [p_nbits-1:0]           b_shifted,
  output logic [$clog2(p_nbits+1)-1:0] shamt
);

  localparam int cnt_w = $clog2(p_nbits + 1);

  // trailing zeros seen so far, capped
  logic [cnt_w-1:0] zeros;
  // still inside the zero run
  logic             run_open;

  // walk the low bits, stop at the first one,
  // at p_max_skip, or at the bits left to consume
  always_comb begin
    zeros    = '0;
    run_open = 1'b1;
    for (int i = 0; i < p_max_skip; i++) begin
      if (run_open && !b[i] && (cnt_w'(i) < remaining)) begin
        zeros = cnt_w'(i + 1);
      end else begin
        run_open = 1'b0;
      end
    end
  end

  // low bit set, or nothing to skip: single step
  assign shamt     = (zeros == '0) ? cnt_w'(1) : zeros;
  assign b_shifted = b >> shamt;

  // a skip drops only zero bits and stays within the bits left
  always_comb begin
    if (remaining != '0) begin
      assert (shamt <= remaining)
        else $error("shamt %0d past %0d remaining bits", shamt, remaining);
      if (!b[0]) begin
        assert ((b << (p_nbits - int'(shamt))) == '0)
          else $error("zero skip of %0d drops a set bit", shamt);
      end
    end
  end

endmodule

/* imul_bit_counter.sv */
// ------------------------------
// consumed multiplier bit counter
// adds a variable step, flags done
// ------------------------------

module imul_bit_counter #(
  parameter int p_nbits = 32
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         clear,
  input  logic                         step,
  input  logic [$clog2(p_nbits+1)-1:0] amount,
  output logic [$clog2(p_nbits+1)-1:0] remaining,
  output logic                         done
);

  localparam int cnt_w = $clog2(p_nbits + 1);

  // count value meaning all bits consumed
  localparam logic [cnt_w-1:0] full = cnt_w'(p_nbits);

  logic [cnt_w-1:0] count;

  // ------------------------------
  // count register
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      count <= '0;
    end else if (step) begin
      // amount already limited by remaining in the shifter
      count <= count + amount;
    end
  end

  // ------------------------------
  // status
  // ------------------------------

  // bits still to consume, caps the next skip
  assign remaining = full - count;
  assign done      = (count == full);

  // shifter limit and FSM stop keep the count in range
  count_in_range: assert property (
    @(posedge clk) disable iff (reset)
    count <= full
  ) else $error("bit count %0d past %0d", count, p_nbits);

endmodule

/* imul_dpath.sv */
// ------------------------------
// imul datapath
// operand, result regs and step logic
// ------------------------------

module imul_dpath #(
  parameter int p_nbits    = 32,
  parameter int p_max_skip = 8
) (
  input  logic                  clk,
  input  logic                  reset,

  // data
  input  logic [2*p_nbits-1:0]  istream_msg,
  output logic [p_nbits-1:0]    ostream_msg,

  // control in
  input  imul_pkg::a_sel_e      a_sel,
  input  imul_pkg::b_sel_e      b_sel,
  input  imul_pkg::result_sel_e result_sel,
  input  logic                  a_en,
  input  logic                  b_en,
  input  logic                  result_en,
  input  logic                  count_clear,

  // status out
  output logic                  b_lsb,
  output logic                  count_done
);

  import imul_pkg::*;

  localparam int msg_w = 2 * p_nbits;
  localparam int cnt_w = $clog2(p_nbits + 1);

  // operand halves, a on top
  logic [p_nbits-1:0] msg_a;
  logic [p_nbits-1:0] msg_b;

  logic [p_nbits-1:0] a_reg;
  logic [p_nbits-1:0] b_reg;
  logic [p_nbits-1:0] result_reg;

  logic [p_nbits-1:0] a_shifted;
  logic [p_nbits-1:0] b_shifted;
  logic [p_nbits-1:0] sum;

  logic [cnt_w-1:0]   shamt;
  logic [cnt_w-1:0]   remaining;

  assign msg_a = istream_msg[msg_w-1:p_nbits];
  assign msg_b = istream_msg[p_nbits-1:0];

  // ------------------------------
  // operand and result registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= (a_sel == a_load) ? msg_a : a_shifted;
    end
    if (b_en) begin
      b_reg <= (b_sel == b_load) ? msg_b : b_shifted;
    end
    if (result_en) begin
      result_reg <= (result_sel == result_clear) ? '0 : sum;
    end
  end

  // ------------------------------
  // step logic
  // ------------------------------

  // partial product accumulate
  assign sum = a_reg + result_reg;

  // a follows b by the same shift
  assign a_shifted = a_reg << shamt;

  imul_zero_skip_shifter #(
    .p_nbits    (p_nbits),
    .p_max_skip (p_max_skip)
  ) b_shifter (
    .b         (b_reg),
    .remaining (remaining),
    .b_shifted (b_shifted),
    .shamt     (shamt)
  );

  // every b shift outside a load is a step
  imul_bit_counter #(
    .p_nbits (p_nbits)
  ) bit_counter (
    .clk       (clk),
    .reset     (reset),
    .clear     (count_clear),
    .step      (b_en && !count_clear),
    .amount    (shamt),
    .remaining (remaining),
    .done      (count_done)
  );

  // status and result out
  assign b_lsb       = b_reg[0];
  assign ostream_msg = result_reg;

endmodule

/* imul_ctrl.sv */
// ------------------------------
// imul control FSM
// idle, calc and done with handshake
// ------------------------------

module imul_ctrl (
  input  logic                  clk,
  input  logic                  reset,

  // stream handshake
  input  logic                  istream_val,
  output logic                  istream_rdy,
  output logic                  ostream_val,
  input  logic                  ostream_rdy,

  // status from datapath
  input  logic                  b_lsb,
  input  logic                  count_done,

  // datapath controls
  output imul_pkg::a_sel_e      a_sel,
  output imul_pkg::b_sel_e      b_sel,
  output imul_pkg::result_sel_e result_sel,
  output logic                  a_en,
  output logic                  b_en,
  output logic                  result_en,
  output logic                  count_clear
);

  import imul_pkg::*;

  imul_state_e state;
  imul_state_e state_next;

  logic req_go;
  logic resp_go;

  assign req_go  = istream_val && istream_rdy;
  assign resp_go = ostream_val && ostream_rdy;

  // ------------------------------
  // state register and transitions
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= state_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      state_idle: if (req_go) state_next = state_calc;
      state_calc: if (count_done) state_next = state_done;
      state_done: if (resp_go) state_next = state_idle;
      default:    state_next = state_idle;
    endcase
  end

  // ------------------------------
  // control signal table
  // ------------------------------

  always_comb begin
    // defaults: hold everything
    istream_rdy = 1'b0;
    ostream_val = 1'b0;
    a_sel       = a_load;
    b_sel       = b_load;
    result_sel  = result_clear;
    a_en        = 1'b0;
    b_en        = 1'b0;
    result_en   = 1'b0;
    count_clear = 1'b0;
    case (state)
      state_idle: begin
        // load operands each cycle, clear sum and count
        istream_rdy = 1'b1;
        a_en        = 1'b1;
        b_en        = 1'b1;
        result_en   = 1'b1;
        count_clear = 1'b1;
      end
      state_calc: begin
        // shift every step, add only on a set bit
        if (!count_done) begin
          a_sel      = a_shift;
          b_sel      = b_shift;
          result_sel = result_add;
          a_en       = 1'b1;
          b_en       = 1'b1;
          result_en  = b_lsb;
        end
      end
      state_done: begin
        ostream_val = 1'b1;
      end
      default: begin
        istream_rdy = 1'b0;
      end
    endcase
  end

  // response only once every multiplier bit is consumed
  done_full_count: assert property (
    @(posedge clk) disable iff (reset)
    ostream_val |-> count_done
  ) else $error("ostream_val high before all bits consumed");

  // accepted request starts with bits to consume
  start_clears_count: assert property (
    @(posedge clk) disable iff (reset)
    req_go |=> !count_done
  ) else $error("bit count not cleared on request accept");

endmodule

/* imul_var_lat.sv */
// ------------------------------
// variable-latency 32-bit multiplier
// low half of a*b on val/rdy streams
// ------------------------------

module imul_var_lat #(
  parameter int p_nbits    = 32,
  parameter int p_max_skip = 8
) (
  input  logic                 clk,
  input  logic                 reset,

  input  logic                 istream_val,
  output logic                 istream_rdy,
  input  logic [2*p_nbits-1:0] istream_msg,

  output logic                 ostream_val,
  input  logic                 ostream_rdy,
  output logic [p_nbits-1:0]   ostream_msg
);

  import imul_pkg::*;

  // control to datapath
  a_sel_e      a_sel;
  b_sel_e      b_sel;
  result_sel_e result_sel;
  logic        a_en;
  logic        b_en;
  logic        result_en;
  logic        count_clear;

  // datapath to control
  logic        b_lsb;
  logic        count_done;

  imul_ctrl ctrl (
    .clk         (clk),
    .reset       (reset),
    .istream_val (istream_val),
    .istream_rdy (istream_rdy),
    .ostream_val (ostream_val),
    .ostream_rdy (ostream_rdy),
    .b_lsb       (b_lsb),
    .count_done  (count_done),
    .a_sel       (a_sel),
    .b_sel       (b_sel),
    .result_sel  (result_sel),
    .a_en        (a_en),
    .b_en        (b_en),
    .result_en   (result_en),
    .count_clear (count_clear)
  );

  imul_dpath #(
    .p_nbits    (p_nbits),
    .p_max_skip (p_max_skip)
  ) dpath (
    .clk         (clk),
    .reset       (reset),
    .istream_msg (istream_msg),
    .ostream_msg (ostream_msg),
    .a_sel       (a_sel),
    .b_sel       (b_sel),
    .result_sel  (result_sel),
    .a_en        (a_en),
    .b_en        (b_en),
    .result_en   (result_en),
    .count_clear (count_clear),
    .b_lsb       (b_lsb),
    .count_done  (count_done)
  );

endmodule

/* tb_imul_var_lat.sv */
// ------------------------------
// imul_var_lat testbench
// table and random operands with back-pressure
// ------------------------------

module tb_imul_var_lat;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int nbits          = 32;
  localparam int timeout_cycles = 100;
  // b of zero and b of all ones at the default skip of 8
  localparam int min_latency    = 6;
  localparam int max_latency    = 34;

  logic               clk;
  logic               reset;
  logic               istream_val;
  logic               istream_rdy;
  logic [2*nbits-1:0] istream_msg;
  logic               ostream_val;
  logic               ostream_rdy;
  logic [nbits-1:0]   ostream_msg;

  // stimulus table, one index per test
  string            names[$];
  logic [nbits-1:0] a_tab[$];
  logic [nbits-1:0] b_tab[$];
  int               delay_tab[$];
  // zero means bounded only
  int               latency_tab[$];

  integer seed;

  imul_var_lat UUT (
    .clk         (clk),
    .reset       (reset),
    .istream_val (istream_val),
    .istream_rdy (istream_rdy),
    .istream_msg (istream_msg),
    .ostream_val (ostream_val),
    .ostream_rdy (ostream_rdy),
    .ostream_msg (ostream_msg)
  );

  always #5 clk = ~clk;

  // ------------------------------
  // error handling and compares
  // ------------------------------

  task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s did not complete within %0d cycles", what, timeout_cycles);
    stop_with_failure();
  endtask

  task automatic check_product(input string name, input logic [nbits-1:0] expected,
                               input logic [nbits-1:0] actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %b, actual %b", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_latency(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("Fail %s latency: expected %0d, actual %0d", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic add_entry(input string name, input logic [nbits-1:0] a,
                           input logic [nbits-1:0] b, input int delay, input int latency);
    names.push_back(name);
    a_tab.push_back(a);
    b_tab.push_back(b);
    delay_tab.push_back(delay);
    latency_tab.push_back(latency);
  endtask

  // ------------------------------
  // one request and response
  // ------------------------------

  task automatic run_entry(input int idx);
    string            name;
    logic [nbits-1:0] expected;
    logic [nbits-1:0] held_msg;
    int               cycles;
    int               edges;
    int               i;
    name     = names[idx];
    // low half of the full product
    expected = a_tab[idx] * b_tab[idx];

    // present the request until accepted
    @(posedge clk);
    istream_val <= 1'b1;
    istream_msg <= {a_tab[idx], b_tab[idx]};
    cycles = 0;
    @(negedge clk);
    while (!istream_rdy) begin
      cycles++;
      if (cycles > timeout_cycles) report_timeout({name, " request handshake"});
      @(negedge clk);
    end
    // accepting edge
    @(posedge clk);
    istream_val <= 1'b0;
    istream_msg <= '0;

    // count edges until ostream_val
    // the accepting edge is the first one
    edges = 1;
    @(negedge clk);
    while (!ostream_val) begin
      check_flag({name, " istream_rdy in flight"}, 1'b0, istream_rdy);
      @(posedge clk);
      edges++;
      if (edges > timeout_cycles) report_timeout({name, " response valid"});
      @(negedge clk);
    end
    if (latency_tab[idx] != 0) begin
      check_latency(name, latency_tab[idx], edges);
    end else if (edges < min_latency || edges > max_latency) begin
      $display("latency of %0d cycles for %s is outside %0d to %0d",
               edges, name, min_latency, max_latency);
      stop_with_failure();
    end
    check_product(name, expected, ostream_msg);

    // back-pressure, response must hold
    held_msg = ostream_msg;
    for (i = 0; i < delay_tab[idx]; i++) begin
      @(posedge clk);
      @(negedge clk);
      check_flag({name, " ostream_val held"}, 1'b1, ostream_val);
      check_product({name, " held result"}, held_msg, ostream_msg);
      check_flag({name, " istream_rdy held"}, 1'b0, istream_rdy);
    end

    // release the response
    @(posedge clk);
    ostream_rdy <= 1'b1;
    cycles = 0;
    @(negedge clk);
    while (!(ostream_val && ostream_rdy)) begin
      cycles++;
      if (cycles > timeout_cycles) report_timeout({name, " response handshake"});
      @(negedge clk);
    end
    // response transfer edge
    @(posedge clk);
    ostream_rdy <= 1'b0;
    @(negedge clk);
    check_flag({name, " istream_rdy after response"}, 1'b1, istream_rdy);
    check_flag({name, " ostream_val after response"}, 1'b0, ostream_val);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    int n;
    int idx;
    seed        = 30;
    clk         = 1'b0;
    reset       = 1'b1;
    istream_val = 1'b0;
    istream_msg = '0;
    ostream_rdy = 1'b0;

    // name, a, b, back-pressure cycles, latency
    add_entry("zero a",          32'h0000_0000, 32'h1234_5678, 0, 0);
    add_entry("zero b",          32'hdead_beef, 32'h0000_0000, 1, 6);
    add_entry("one times one",   32'h0000_0001, 32'h0000_0001, 0, 7);
    add_entry("one times x",     32'h0000_0001, 32'h89ab_cdef, 2, 0);
    add_entry("all ones",        32'hffff_ffff, 32'hffff_ffff, 3, 34);
    add_entry("largest signed",  32'h7fff_ffff, 32'h7fff_ffff, 0, 34);
    add_entry("single high bit", 32'h1234_5679, 32'h8000_0000, 1, 7);
    add_entry("sparse b",        32'h0000_0003, 32'h0001_0000, 0, 7);
    add_entry("max a times two", 32'hffff_ffff, 32'h0000_0002, 1, 8);
    add_entry("alternating 10",  32'h0f0f_0f0f, 32'haaaa_aaaa, 0, 34);
    add_entry("alternating 01",  32'hf0f0_f0f0, 32'h5555_5555, 2, 34);

    // random operands, delay 0 to 3
    for (n = 0; n < 20; n++) begin
      add_entry($sformatf("random %0d", n), $random(seed), $random(seed),
                $random(seed) & 3, 0);
    end

    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_flag("istream_rdy after reset", 1'b1, istream_rdy);
    check_flag("ostream_val after reset", 1'b0, ostream_val);

    for (idx = 0; idx < names.size(); idx++) begin
      run_entry(idx);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

/* all.f */
imul_pkg.sv
imul_zero_skip_shifter.sv
imul_bit_counter.sv
imul_dpath.sv
imul_ctrl.sv
imul_var_lat.sv
tb_imul_var_lat.sv

/* run.sh */
#!/bin/sh
# build and run the imul_var_lat testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_imul_var_lat -f all.f -o sim_imul

./obj_dir/sim_imul > run.log 2>&1 || true
cat run.log

if grep -q "^All tests passed!$" run.log; then
  echo "simulation PASSED"
  exit 0
else
  echo "simulation FAILED"
  exit 1
fi
